//--- flist.f
mx_shape_pkg.sv
mx_isa_pkg.sv
mx_step_ctrl.sv
mx_operand_buf.sv
mx_accum_unit.sv
mx_mac_top.sv
tb_mx_mac.sv

//--- Makefile
# Verilator build and run for the matrix unit testbench

VERILATOR ?= verilator
TOP       ?= tb_mx_mac
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "Simulation ended without a status, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_mx_mac.sv
`timescale 1ns/10ps

module tb_mx_mac
  import mx_shape_pkg::*;
  import mx_isa_pkg::*;
();

  // Run limit follows the number of issued instructions
  localparam int N_INSTR = 14;
  localparam int TIMEOUT = N_INSTR * 8 + 50;

  logic       dca_port_22;
  logic       dca_port_18;
  logic       start;
  logic       clear;
  mx_inst_t   inst;
  mx_matrix_t lhs;
  mx_matrix_t rhs;
  logic       busy;
  logic       done;
  mx_matrix_t result;
  mx_mask_t   wr_mask;

  mx_matrix_t  model_q;
  mx_matrix_t  exp_result;
  mx_mask_t    exp_mask;
  logic        abort_win;
  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  int          sva_err = 0;
  int          chk_err;
  int          test_base;
  int          pass_cnt;
  int          fail_cnt;

  mx_mac_top dut_i (
    .dca_port_22 (dca_port_22),
    .dca_port_18 (dca_port_18),
    .i_start     (start),
    .i_inst      (inst),
    .i_lhs       (lhs),
    .i_rhs       (rhs),
    .i_clear     (clear),
    .o_busy      (busy),
    .o_done      (done),
    .o_result    (result),
    .o_wr_mask   (wr_mask)
  );

  initial
  begin
    dca_port_22 = 1'b0;
    forever #4 dca_port_22 = ~dca_port_22;
  end

  always @(posedge dca_port_22)
  begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT)
    begin
      $display("Run stopped after %0d cycles without finishing", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ****************************************
  // Stimulus and reference model
  // ****************************************
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Small signed values, -8 to 7
  function automatic mx_matrix_t rand_matrix();
    mx_matrix_t  m;
    logic [31:0] v;
    for (int r = 0; r < MX_ROWS; r++)
      for (int c = 0; c < MX_COLS; c++)
      begin
        v = lcg_next();
        m[r][c] = mx_elem_t'(int'(v[19:16]) - 8);
      end
    return m;
  endfunction

  function automatic mx_inst_t make_inst(mx_op_e op, logic init_acc, int k);
    mx_inst_t    i;
    logic [31:0] v;
    v = lcg_next();
    i.op        = op;
    i.init_acc  = init_acc;
    i.inner_dim = MX_DIM_W'(k);
    i.row_mask  = v[23:20];
    i.col_mask  = v[27:24];
    return i;
  endfunction

  // Expected matrix, 16-bit wraparound, unmasked elements keep prev
  function automatic mx_matrix_t model_result(mx_inst_t i, mx_matrix_t a, mx_matrix_t b,
                                               mx_matrix_t prev);
    mx_matrix_t m;
    mx_elem_t   v;
    m = prev;
    for (int r = 0; r < MX_ROWS; r++)
      for (int c = 0; c < MX_COLS; c++)
      begin
        case (i.op)
          OP_ADD:   v = a[r][c] + b[r][c];
          OP_SUB:   v = a[r][c] - b[r][c];
          OP_EWMUL: v = a[r][c] * b[r][c];
          default:
          begin
            v = i.init_acc ? mx_elem_t'(0) : prev[r][c];
            for (int k = 0; k < int'(i.inner_dim); k++)
              v = v + a[r][k] * b[k][c];
          end
        endcase
        if (i.row_mask[r] && i.col_mask[c])
          m[r][c] = v;
      end
    return m;
  endfunction

  function automatic mx_mask_t model_mask(mx_inst_t i);
    mx_mask_t m;
    for (int r = 0; r < MX_ROWS; r++)
      for (int c = 0; c < MX_COLS; c++)
        m[r*MX_COLS+c] = i.row_mask[r] & i.col_mask[c];
    return m;
  endfunction

  task automatic check_eq(input string name, input logic [255:0] got, input logic [255:0] exp);
    assert (got == exp)
    else
    begin
      $display("MISMATCH %s got %0h exp %0h", name, got, exp);
      chk_err++;
    end
  endtask

  // Called on a falling edge while the DUT is idle
  task automatic run_op(input mx_inst_t i);
    int lat;
    int exp_lat;
    lhs        = rand_matrix();
    rhs        = rand_matrix();
    inst       = i;
    start      = 1'b1;
    exp_result = model_result(i, lhs, rhs, model_q);
    exp_mask   = model_mask(i);
    exp_lat    = (i.op == OP_MATMUL) ? int'(i.inner_dim) + 3 : ((i.op == OP_EWMUL) ? 3 : 2);
    @(negedge dca_port_22);
    start = 1'b0;
    lat   = 0;
    while (!done)
    begin
      @(negedge dca_port_22);
      lat++;
    end
    check_eq("latency", 256'(lat), 256'(exp_lat));
    model_q = exp_result;
    // Result checks fire on the next rising edge
    @(negedge dca_port_22);
  endtask

  task automatic finish_test(input string name);
    int n;
    n = sva_err + chk_err - test_base;
    if (n == 0)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test %s %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
    test_base = sva_err + chk_err;
  endtask

  // ****************************************
  // Output checks
  // ****************************************
  a_result: assert property (@(posedge dca_port_22) disable iff (!dca_port_18)
    done |-> result == exp_result)
  else
  begin
    $display("MISMATCH o_result got %h exp %h", result, exp_result);
    sva_err++;
  end

  a_mask: assert property (@(posedge dca_port_22) disable iff (!dca_port_18)
    done |-> wr_mask == exp_mask)
  else
  begin
    $display("MISMATCH o_wr_mask got %h exp %h", wr_mask, exp_mask);
    sva_err++;
  end

  a_mask_idle: assert property (@(posedge dca_port_22) disable iff (!dca_port_18)
    !done |-> wr_mask == '0)
  else
  begin
    $display("MISMATCH o_wr_mask got %h exp 0", wr_mask);
    sva_err++;
  end

  a_done_busy: assert property (@(posedge dca_port_22) disable iff (!dca_port_18)
    done |-> $past(busy))
  else
  begin
    $display("o_done came without a busy instruction");
    sva_err++;
  end

  a_done_pulse: assert property (@(posedge dca_port_22) disable iff (!dca_port_18)
    done |=> !done)
  else
  begin
    $display("o_done stayed high for more than one cycle");
    sva_err++;
  end

  a_no_done: assert property (@(posedge dca_port_22) disable iff (!dca_port_18)
    abort_win |-> !done)
  else
  begin
    $display("o_done followed an aborted instruction");
    sva_err++;
  end

  initial
  begin
    lcg_state   = 32'd70;
    chk_err     = 0;
    test_base   = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    dca_port_18 = 1'b0;
    start       = 1'b0;
    clear       = 1'b0;
    inst        = '0;
    lhs         = '0;
    rhs         = '0;
    model_q     = '0;
    exp_result  = '0;
    exp_mask    = '0;
    abort_win   = 1'b0;
    repeat (2) @(posedge dca_port_22);
    @(negedge dca_port_22);
    dca_port_18 = 1'b1;

    check_eq("o_busy", 256'(busy), 256'(0));
    check_eq("o_done", 256'(done), 256'(0));
    check_eq("o_result", 256'(result), 256'(0));
    check_eq("o_wr_mask", 256'(wr_mask), 256'(0));
    finish_test("reset");

    for (int n = 0; n < 4; n++)
      run_op(make_inst((n % 2 == 0) ? OP_ADD : OP_SUB, 1'b0, 0));
    finish_test("add_sub");

    for (int n = 0; n < 2; n++)
      run_op(make_inst(OP_EWMUL, 1'b0, 0));
    finish_test("ewmul");

    for (int k = 1; k <= 4; k++)
      run_op(make_inst(OP_MATMUL, 1'b1, k));
    finish_test("matmul_init");

    run_op(make_inst(OP_MATMUL, 1'b0, 4));
    run_op(make_inst(OP_MATMUL, 1'b0, 2));
    finish_test("matmul_acc");

    // Abort a K=4 matmul two cycles in
    lhs       = rand_matrix();
    rhs       = rand_matrix();
    inst      = make_inst(OP_MATMUL, 1'b1, 4);
    start     = 1'b1;
    abort_win = 1'b1;
    @(negedge dca_port_22);
    start = 1'b0;
    repeat (2) @(negedge dca_port_22);
    clear = 1'b1;
    @(negedge dca_port_22);
    clear = 1'b0;
    check_eq("o_busy", 256'(busy), 256'(0));
    repeat (8) @(negedge dca_port_22);
    check_eq("o_result", 256'(result), 256'(model_q));
    abort_win = 1'b0;
    run_op(make_inst(OP_MATMUL, 1'b0, 3));
    finish_test("clear");

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && sva_err + chk_err == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- mx_mac_top.sv
`timescale 1ns/10ps

module mx_mac_top
  import mx_shape_pkg::*;
  import mx_isa_pkg::*;
(
  input  logic       dca_port_22,
  input  logic       dca_port_18,
  input  logic       i_start,
  input  mx_inst_t   i_inst,
  input  mx_matrix_t i_lhs,
  input  mx_matrix_t i_rhs,
  input  logic       i_clear,
  output logic       o_busy,
  output logic       o_done,
  output mx_matrix_t o_result,
  output mx_mask_t   o_wr_mask
);

  logic       load;
  mx_step_t   step;
  mx_matrix_t lhs_op;
  mx_matrix_t rhs_op;
  logic       last_done;

  mx_step_ctrl u_ctrl (
    .dca_port_22 (dca_port_22),
    .dca_port_18 (dca_port_18),
    .i_clear     (i_clear),
    .i_start     (i_start),
    .i_inst      (i_inst),
    .i_last_done (last_done),
    .o_load      (load),
    .o_step      (step),
    .o_busy      (o_busy),
    .o_done      (o_done)
  );

  mx_operand_buf u_buf (
    .dca_port_22 (dca_port_22),
    .dca_port_18 (dca_port_18),
    .i_load      (load),
    .i_step      (step),
    .i_lhs       (i_lhs),
    .i_rhs       (i_rhs),
    .o_lhs_op    (lhs_op),
    .o_rhs_op    (rhs_op)
  );

  mx_accum_unit u_acc (
    .dca_port_22 (dca_port_22),
    .dca_port_18 (dca_port_18),
    .i_clear     (i_clear),
    .i_step      (step),
    .i_lhs_op    (lhs_op),
    .i_rhs_op    (rhs_op),
    .o_result    (o_result),
    .o_wr_mask   (o_wr_mask),
    .o_last_done (last_done)
  );

endmodule

//--- mx_accum_unit.sv
`timescale 1ns/10ps

module mx_accum_unit
  import mx_shape_pkg::*;
  import mx_isa_pkg::*;
(
  input  logic       dca_port_22,
  input  logic       dca_port_18,
  input  logic       i_clear,
  input  mx_step_t   i_step,
  input  mx_matrix_t i_lhs_op,
  input  mx_matrix_t i_rhs_op,
  output mx_matrix_t o_result,
  output mx_mask_t   o_wr_mask,
  output logic       o_last_done
);

  mx_step_t   pipe_q [MX_MUL_LAT+MX_ADD_LAT];
  mx_step_t   add_st;
  mx_step_t   mul_st;
  mx_step_t   acc_st;
  mx_step_t   wr_st;
  logic       do_add;
  logic       do_mul;
  logic       do_prod;
  logic       do_acc;
  logic       wr_add;
  logic       wr_mul;
  logic       wr_mm;
  logic       wr_en;
  mx_matrix_t ml_q;
  mx_matrix_t mr_q;
  mx_matrix_t prod_q;
  mx_matrix_t sum_q;
  mx_matrix_t result_q;
  mx_mask_t   elem_mask;
  mx_mask_t   wr_mask_q;

  // Step info as seen at the output of each datapath stage
  assign add_st = pipe_q[MX_ADD_LAT-1];
  assign mul_st = pipe_q[MX_MUL_LAT-1];
  assign acc_st = pipe_q[MX_MUL_LAT+MX_ADD_LAT-1];

  assign do_add  = i_step.valid && (i_step.op inside {OP_ADD, OP_SUB});
  assign do_mul  = i_step.valid && (i_step.op inside {OP_EWMUL, OP_MATMUL});
  assign do_prod = pipe_q[0].valid && (pipe_q[0].op inside {OP_EWMUL, OP_MATMUL});
  assign do_acc  = mul_st.valid && (mul_st.op == OP_MATMUL);

  assign wr_add = add_st.valid && add_st.last && (add_st.op inside {OP_ADD, OP_SUB});
  assign wr_mul = mul_st.valid && mul_st.last && (mul_st.op == OP_EWMUL);
  assign wr_mm  = acc_st.valid && acc_st.last && (acc_st.op == OP_MATMUL);
  assign wr_en  = (wr_add || wr_mul || wr_mm) && !i_clear;
  assign wr_st  = wr_mm ? acc_st : (wr_mul ? mul_st : add_st);

  // ****************************************
  // Step pipeline
  // ****************************************
  always_ff @(posedge dca_port_22 or negedge dca_port_18)
  begin
    if (!dca_port_18)
    begin
      for (int i = 0; i < MX_MUL_LAT+MX_ADD_LAT; i++)
        pipe_q[i] <= '0;
      wr_mask_q <= '0;
    end
    else if (i_clear)
    begin
      for (int i = 0; i < MX_MUL_LAT+MX_ADD_LAT; i++)
        pipe_q[i] <= '0;
      wr_mask_q <= '0;
    end
    else
    begin
      pipe_q[0] <= i_step;
      for (int i = 1; i < MX_MUL_LAT+MX_ADD_LAT; i++)
        pipe_q[i] <= pipe_q[i-1];
      wr_mask_q <= wr_en ? elem_mask : '0;
    end
  end

  // ****************************************
  // Element datapath
  // ****************************************
  for (genvar r = 0; r < MX_ROWS; r++)
  begin : g_row
    for (genvar c = 0; c < MX_COLS; c++)
    begin : g_col
      mx_elem_t                      add_a;
      mx_elem_t                      add_b;
      logic                          sub;
      logic signed [2*MX_ELEM_W-1:0] full_prod;

      // Shared adder, either operands or accumulate
      always_comb
      begin
        add_a = i_lhs_op[r][c];
        add_b = i_rhs_op[r][c];
        if (do_acc)
        begin
          if (!mul_st.first)
            add_a = sum_q[r][c];
          else if (mul_st.init_acc)
            add_a = '0;
          else
            add_a = result_q[r][c];
          add_b = prod_q[r][c];
        end
      end

      assign sub       = (i_step.op == OP_SUB) && !do_acc;
      assign full_prod = ml_q[r][c] * mr_q[r][c];

      always_ff @(posedge dca_port_22)
      begin
        if (do_add || do_acc)
          sum_q[r][c] <= sub ? add_a - add_b : add_a + add_b;
        if (do_mul)
        begin
          ml_q[r][c] <= i_lhs_op[r][c];
          mr_q[r][c] <= i_rhs_op[r][c];
        end
        if (do_prod)
          prod_q[r][c] <= mx_elem_t'(full_prod);
      end

      assign elem_mask[r*MX_COLS+c] = wr_st.row_mask[r] & wr_st.col_mask[c];

      always_ff @(posedge dca_port_22 or negedge dca_port_18)
      begin
        if (!dca_port_18)
          result_q[r][c] <= '0;
        else if (wr_en && elem_mask[r*MX_COLS+c])
          result_q[r][c] <= wr_mul ? prod_q[r][c] : sum_q[r][c];
      end
    end
  end

  assign o_result    = result_q;
  assign o_wr_mask   = wr_mask_q;
  assign o_last_done = wr_en;

endmodule

//--- mx_operand_buf.sv
`timescale 1ns/10ps

module mx_operand_buf
  import mx_shape_pkg::*;
  import mx_isa_pkg::*;
(
  input  logic       dca_port_22,
  input  logic       dca_port_18,
  input  logic       i_load,
  input  mx_step_t   i_step,
  input  mx_matrix_t i_lhs,
  input  mx_matrix_t i_rhs,
  output mx_matrix_t o_lhs_op,
  output mx_matrix_t o_rhs_op
);

  mx_matrix_t a_q;
  mx_matrix_t b_q;
  logic       loaded_q;
  logic       shift;
  logic       sel;

  assign shift = i_step.valid && (i_step.op == OP_MATMUL) && !i_step.first;

  // Registers shift one step late, so later steps read one column/row ahead
  assign sel = shift;

  // ****************************************
  // Operand storage
  // ****************************************
  always_ff @(posedge dca_port_22)
  begin
    if (i_load)
    begin
      a_q <= i_lhs;
      b_q <= i_rhs;
    end
    else if (shift)
    begin
      for (int r = 0; r < MX_ROWS; r++)
      begin
        a_q[r] <= {mx_elem_t'(0), a_q[r][MX_COLS-1:1]};
      end
      b_q <= {mx_row_t'(0), b_q[MX_ROWS-1:1]};
    end
  end

  always_ff @(posedge dca_port_22 or negedge dca_port_18)
  begin
    if (!dca_port_18)
      loaded_q <= 1'b0;
    else if (i_load)
      loaded_q <= 1'b1;
  end

  // ****************************************
  // Operand view
  // ****************************************
  always_comb
  begin
    o_lhs_op = a_q;
    o_rhs_op = b_q;
    if (i_step.op == OP_MATMUL)
    begin
      // Outer product broadcast
      for (int r = 0; r < MX_ROWS; r++)
      begin
        for (int c = 0; c < MX_COLS; c++)
        begin
          o_lhs_op[r][c] = a_q[r][sel];
          o_rhs_op[r][c] = b_q[sel][c];
        end
      end
    end
  end

  a_shift_loaded: assert property (@(posedge dca_port_22) disable iff (!dca_port_18)
    shift |-> loaded_q)
    else $error("operand shift before any load");

endmodule

//--- mx_step_ctrl.sv
`timescale 1ns/10ps

module mx_step_ctrl
  import mx_shape_pkg::*;
  import mx_isa_pkg::*;
(
  input  logic     dca_port_22,
  input  logic     dca_port_18,
  input  logic     i_clear,
  input  logic     i_start,
  input  mx_inst_t i_inst,
  input  logic     i_last_done,
  output logic     o_load,
  output mx_step_t o_step,
  output logic     o_busy,
  output logic     o_done
);

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_e;

  state_e              state_q;
  mx_step_t            step_q;
  mx_step_t            first_step;
  logic [MX_DIM_W-1:0] cnt_q;
  logic [MX_DIM_W-1:0] cnt_nxt;
  logic [MX_DIM_W-1:0] dim_q;
  logic                done_q;
  logic                accept;

  assign accept  = i_start && (state_q == ST_IDLE) && !i_clear;
  assign cnt_nxt = cnt_q + 1'b1;

  always_comb
  begin
    first_step.valid    = 1'b1;
    first_step.op       = i_inst.op;
    first_step.first    = 1'b1;
    // Element-wise ops issue one step only
    first_step.last     = (i_inst.op != OP_MATMUL) || (i_inst.inner_dim == MX_DIM_W'(1));
    first_step.init_acc = i_inst.init_acc;
    first_step.row_mask = i_inst.row_mask;
    first_step.col_mask = i_inst.col_mask;
  end

  always_ff @(posedge dca_port_22)
  begin
    if (accept)
      dim_q <= i_inst.inner_dim;
  end

  // ****************************************
  // Idle/run sequencer
  // ****************************************
  always_ff @(posedge dca_port_22 or negedge dca_port_18)
  begin
    if (!dca_port_18)
    begin
      state_q <= ST_IDLE;
      step_q  <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end
    else if (i_clear)
    begin
      state_q      <= ST_IDLE;
      step_q.valid <= 1'b0;
      done_q       <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          if (accept)
          begin
            state_q <= ST_RUN;
            step_q  <= first_step;
            cnt_q   <= MX_DIM_W'(1);
          end
        end
        ST_RUN:
        begin
          if (step_q.valid)
          begin
            if (step_q.last)
              step_q.valid <= 1'b0;
            else
            begin
              step_q.first <= 1'b0;
              step_q.last  <= (cnt_nxt == dim_q);
              cnt_q        <= cnt_nxt;
            end
          end
          // Final result is written on this edge
          if (i_last_done)
          begin
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
          end
        end
      endcase
    end
  end

  assign o_load = accept;
  assign o_step = step_q;
  assign o_busy = (state_q == ST_RUN);
  assign o_done = done_q;

  // ****************************************
  // Checks
  // ****************************************
  a_start_idle: assert property (@(posedge dca_port_22) disable iff (!dca_port_18)
    i_start |-> !o_busy)
    else $error("i_start while busy");

  a_dim_legal: assert property (@(posedge dca_port_22) disable iff (!dca_port_18)
    accept && (i_inst.op == OP_MATMUL) |-> i_inst.inner_dim inside {[1:MX_ROWS]})
    else $error("illegal inner dimension %0d", i_inst.inner_dim);

endmodule

//--- mx_isa_pkg.sv
package mx_isa_pkg;

  typedef enum logic [1:0] {
    OP_ADD    = 2'd0,
    OP_SUB    = 2'd1,
    OP_EWMUL  = 2'd2,
    OP_MATMUL = 2'd3
  } mx_op_e;

  // Pipeline depth of the element datapath
  localparam int MX_ADD_LAT = 1;
  localparam int MX_MUL_LAT = 2;

  // ****************************************
  // Instruction word
  // ****************************************
  typedef struct packed {
    logic [mx_shape_pkg::MX_DIM_W-1:0] inner_dim;
    mx_shape_pkg::mx_rowmask_t         row_mask;
    mx_shape_pkg::mx_colmask_t         col_mask;
    logic                              init_acc;
    mx_op_e                            op;
  } mx_inst_t;

  // ****************************************
  // One issued step
  // ****************************************
  typedef struct packed {
    logic                      valid;
    mx_op_e                    op;
    logic                      first;
    logic                      last;
    logic                      init_acc;
    mx_shape_pkg::mx_rowmask_t row_mask;
    mx_shape_pkg::mx_colmask_t col_mask;
  } mx_step_t;

endpackage

//--- mx_shape_pkg.sv
package mx_shape_pkg;

  // Matrix shape
  localparam int MX_ROWS  = 4;
  localparam int MX_COLS  = 4;
  localparam int MX_ELEMS = MX_ROWS * MX_COLS;

  localparam int MX_ELEM_W = 16;

  // Inner dimension field, legal values 1 to MX_ROWS
  localparam int MX_DIM_W = 3;

  typedef logic signed [MX_ELEM_W-1:0] mx_elem_t;

  typedef mx_elem_t [MX_COLS-1:0] mx_row_t;

  // Row 0 column 0 sits in the low bits, index is row*MX_COLS+col
  typedef mx_row_t [MX_ROWS-1:0] mx_matrix_t;

  typedef logic [MX_ROWS-1:0] mx_rowmask_t;
  typedef logic [MX_COLS-1:0] mx_colmask_t;

  // Same element order as mx_matrix_t
  typedef logic [MX_ELEMS-1:0] mx_mask_t;

endpackage
